//--- rsp_data_pkg.sv
// Payload types for the request, response and ordered output ports
package rsp_data_pkg;

    // ==================================================
    // Payload widths
    // ==================================================

    // Response data word returned by memory and delivered in order
    typedef logic [31:0] data_t;

    // Request tag kept as ROB metadata and paired with the data on output
    typedef logic [7:0] meta_t;

    // Request address forwarded to the memory port
    typedef logic [15:0] addr_t;

endpackage

//--- rob_pkg.sv
// ROB default geometry, output queue depth and valid-RAM initialiser states
package rob_pkg;

    // ==================================================
    // Reorder buffer geometry
    // ==================================================

    // Slot count of the ring, must be a power of two
    localparam int ROB_ENTRIES = 16;

    // not_full drops when no more than this many slots remain free
    localparam int ROB_MIN_FREE = 1;

    // ==================================================
    // Output side
    // ==================================================

    // Two reads in flight plus two words held while the sink stalls
    localparam int OUT_QUEUE_DEPTH = 4;

    // States of the self-clearing valid-bit RAM
    typedef enum logic {init_clear, init_done} init_state_t;

endpackage

//--- ram_simple.sv
// Simple dual-port RAM with one write port and a two-cycle registered read port
module ram_simple
#(
    parameter int N_ENTRIES = 16,
    parameter int N_DATA_BITS = 32
)
(
    input  logic                         clk,

    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [N_DATA_BITS-1:0]       wdata,

    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0]       rdata
);

    typedef logic [$clog2(N_ENTRIES)-1:0] addr_t;
    typedef logic [N_DATA_BITS-1:0] word_t;

    word_t mem [N_ENTRIES];

    // Read address is captured first, the array output is registered after
    addr_t raddr_q;

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            mem[waddr] <= wdata;
        end
    end

    // Address lands on the first edge and data on the second,
    // so rdata is valid two cycles after raddr was presented
    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata <= mem[raddr_q];
    end

endmodule

//--- lutram_init.sv
// Small RAM that clears every entry after reset and then raises rdy
module lutram_init
#(
    parameter int N_ENTRIES = 8,
    parameter int N_DATA_BITS = 1
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rdy,

    input  logic [$clog2(N_ENTRIES)-1:0] raddr,
    output logic [N_DATA_BITS-1:0]       rdata,

    input  logic                         wen,
    input  logic [$clog2(N_ENTRIES)-1:0] waddr,
    input  logic [N_DATA_BITS-1:0]       wdata
);

    typedef logic [$clog2(N_ENTRIES)-1:0] addr_t;
    typedef logic [N_DATA_BITS-1:0] word_t;

    word_t mem [N_ENTRIES];

    rob_pkg::init_state_t state;
    addr_t init_addr;

    assign rdy = (state == rob_pkg::init_done);

    // ==================================================
    // Clear walk
    // ==================================================

    // One address is cleared per cycle, the last one ends the walk
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= rob_pkg::init_clear;
            init_addr <= '0;
        end
        else if (state == rob_pkg::init_clear)
        begin
            init_addr <= init_addr + addr_t'(1);
            if (&init_addr)
            begin
                state <= rob_pkg::init_done;
            end
        end
    end

    // The clear walk owns the write port until rdy rises
    always_ff @(posedge clk)
    begin
        if (state == rob_pkg::init_clear)
        begin
            mem[init_addr] <= '0;
        end
        else if (wen)
        begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];
    end

    // A user write during the clear would be silently lost
    a_no_write_before_rdy : assert property (@(posedge clk) disable iff (reset)
        wen |-> rdy);

endmodule

//--- rob.sv
// Reorder buffer with slot allocation, tagged valid-bit banks and in-order dequeue
module rob
#(
    parameter int N_ENTRIES = 16,
    parameter int MIN_FREE_SLOTS = 1
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         alloc,
    input  rsp_data_pkg::meta_t          alloc_meta,
    output logic                         not_full,
    output logic [$clog2(N_ENTRIES)-1:0] alloc_idx,

    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_idx,
    input  rsp_data_pkg::data_t          rsp_data,

    input  logic                         deq,
    output logic                         not_empty,
    output rsp_data_pkg::data_t          first_data,
    output rsp_data_pkg::meta_t          first_meta
);

    localparam int IDX_W = $clog2(N_ENTRIES);

    typedef logic [IDX_W-1:0] idx_t;
    // Ring distance that can hold both 0 and N_ENTRIES
    typedef logic [IDX_W:0] dist_t;
    // Index within one valid bank, the low index bit picks the bank
    typedef logic [IDX_W-2:0] bank_idx_t;
    typedef logic [2:0] ready_cnt_t;

    idx_t newest;
    idx_t oldest;
    logic valid_rdy [2];
    logic rdy_all;

    // ==================================================
    // Ring pointers
    // ==================================================

    assign rdy_all = valid_rdy[0] && valid_rdy[1];
    assign alloc_idx = newest;

    // Free space is the wrapped distance from newest up to oldest
    logic newest_ge_oldest;
    assign newest_ge_oldest = (newest >= oldest);
    assign not_full = rdy_all &&
        (({1'b0, newest} + dist_t'(MIN_FREE_SLOTS)) < {newest_ge_oldest, oldest});

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            newest <= '0;
            oldest <= '0;
        end
        else
        begin
            newest <= newest + idx_t'(alloc);
            oldest <= oldest + idx_t'(deq);
        end
    end

    // ==================================================
    // Data arrival tracking
    // ==================================================

    // The meaning of a set valid bit flips on every lap of the ring.
    // A response writes the tag of its own lap, so no bit is ever cleared
    logic valid_tag;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            valid_tag <= 1'b1;
        end
        else if (deq && (&oldest))
        begin
            valid_tag <= ~valid_tag;
        end
    end

    bank_idx_t scan_idx [2];
    logic [0:0] scan_val [2];
    logic scan_bank;
    logic scan_tgt;
    logic scan_hit;
    logic scan_take;
    ready_cnt_t num_ready;

    // Head of the scan holds a response from the current lap
    assign scan_hit = rdy_all && (scan_val[scan_bank][0] == scan_tgt);
    // The counter saturates, the scan simply waits for room
    assign scan_take = scan_hit && (num_ready != '1);
    assign not_empty = (num_ready != '0) || scan_hit;

    // Banks are read alternately so each read has two cycles to return
    always_ff @(posedge clk)
    begin
        if (reset || !rdy_all)
        begin
            scan_idx[0] <= '0;
            scan_idx[1] <= '0;
            scan_bank <= 1'b0;
            scan_tgt <= 1'b1;
        end
        else if (scan_take)
        begin
            scan_idx[scan_bank] <= scan_idx[scan_bank] + bank_idx_t'(1);
            // Leaving the top slot starts a new lap with the inverted tag
            if (scan_bank && (&scan_idx[1]))
            begin
                scan_tgt <= ~scan_tgt;
            end
            scan_bank <= ~scan_bank;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            num_ready <= '0;
        end
        else
        begin
            num_ready <= num_ready - ready_cnt_t'(deq) + ready_cnt_t'(scan_take);
        end
    end

    for (genvar p = 0; p < 2; p++)
    begin : g_valid
        // Slots below oldest have wrapped and belong to the next lap
        lutram_init #(.N_ENTRIES(N_ENTRIES / 2), .N_DATA_BITS(1)) valid_bank_i
        (
            .clk   (clk),
            .reset (reset),
            .rdy   (valid_rdy[p]),
            .raddr (scan_idx[p]),
            .rdata (scan_val[p]),
            .wen   (rsp_valid && (rsp_idx[0] == 1'(p))),
            .waddr (rsp_idx[IDX_W-1:1]),
            .wdata ((rsp_idx >= oldest) ? valid_tag : ~valid_tag)
        );
    end

    // ==================================================
    // Payload and metadata storage
    // ==================================================

    ram_simple #(.N_ENTRIES(N_ENTRIES), .N_DATA_BITS($bits(rsp_data_pkg::data_t))) data_ram_i
    (
        .clk   (clk),
        .wen   (rsp_valid),
        .waddr (rsp_idx),
        .wdata (rsp_data),
        .raddr (oldest),
        .rdata (first_data)
    );

    // Tag is written at allocation time into the slot being granted
    ram_simple #(.N_ENTRIES(N_ENTRIES), .N_DATA_BITS($bits(rsp_data_pkg::meta_t))) meta_ram_i
    (
        .clk   (clk),
        .wen   (alloc),
        .waddr (newest),
        .wdata (alloc_meta),
        .raddr (oldest),
        .rdata (first_meta)
    );

    a_no_alloc_full : assert property (@(posedge clk) disable iff (reset)
        alloc |-> (idx_t'(newest + idx_t'(1)) != oldest));
    a_no_deq_empty : assert property (@(posedge clk) disable iff (reset)
        deq |-> not_empty);
    a_pow2 : assert property (@(posedge clk)
        (N_ENTRIES & (N_ENTRIES - 1)) == 0);

endmodule

//--- req_issue.sv
// Input side: one-entry request holding stage, slot allocation and memory strobe
module req_issue
#(
    parameter int N_ENTRIES = 16
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         req_valid,
    input  rsp_data_pkg::addr_t          req_addr,
    input  rsp_data_pkg::meta_t          req_tag,
    output logic                         req_ready,

    input  logic                         not_full,
    output logic                         alloc,
    output rsp_data_pkg::meta_t          alloc_meta,
    input  logic [$clog2(N_ENTRIES)-1:0] alloc_idx,

    output logic                         mem_req_valid,
    output rsp_data_pkg::addr_t          mem_req_addr,
    output logic [$clog2(N_ENTRIES)-1:0] mem_req_idx
);

    typedef logic [$clog2(N_ENTRIES)-1:0] idx_t;

    logic hold_valid;
    rsp_data_pkg::addr_t hold_addr;
    rsp_data_pkg::meta_t hold_tag;
    logic accept;

    // The held request leaves in the cycle it gets a slot
    assign alloc = hold_valid && not_full;
    assign alloc_meta = hold_tag;
    // A new request may replace one that is being issued
    assign req_ready = !hold_valid || alloc;
    assign accept = req_valid && req_ready;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hold_valid <= 1'b0;
            mem_req_valid <= 1'b0;
        end
        else
        begin
            hold_valid <= accept || (hold_valid && !alloc);
            mem_req_valid <= alloc;
        end
    end

    // Payload registers, qualified by hold_valid and mem_req_valid
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            hold_addr <= req_addr;
            hold_tag <= req_tag;
        end
        if (alloc)
        begin
            mem_req_addr <= hold_addr;
            mem_req_idx <= alloc_idx;
        end
    end

    // Every grant moves the ROB on to the next slot of the ring
    a_next_slot : assert property (@(posedge clk) disable iff (reset)
        alloc |=> (alloc_idx == $past(alloc_idx) + idx_t'(1)));

endmodule

//--- ordered_out.sv
// Output side: dequeue pacing, in-flight tracking and a ready/valid output queue
module ordered_out
(
    input  logic                clk,
    input  logic                reset,

    input  logic                not_empty,
    output logic                deq,
    input  rsp_data_pkg::data_t first_data,
    input  rsp_data_pkg::meta_t first_meta,

    output logic                out_valid,
    output rsp_data_pkg::data_t out_data,
    output rsp_data_pkg::meta_t out_tag,
    input  logic                out_ready
);

    localparam int DEPTH = rob_pkg::OUT_QUEUE_DEPTH;

    typedef logic [$clog2(DEPTH)-1:0] ptr_t;
    typedef logic [$clog2(DEPTH):0] cnt_t;

    rsp_data_pkg::data_t q_data [DEPTH];
    rsp_data_pkg::meta_t q_tag [DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;

    // Bit 0 is a read one cycle old, bit 1 a read whose word is on first_data
    logic [1:0] in_flight;
    logic push;
    logic pop;

    // ==================================================
    // Dequeue pacing
    // ==================================================

    // Every outstanding read already owns a queue slot
    assign deq = not_empty &&
        ((count + cnt_t'(in_flight[0]) + cnt_t'(in_flight[1])) < cnt_t'(DEPTH));

    assign push = in_flight[1];
    assign pop = out_valid && out_ready;

    assign out_valid = (count != '0);
    assign out_data = q_data[rd_ptr];
    assign out_tag = q_tag[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            in_flight <= '0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
        else
        begin
            in_flight <= {in_flight[0], deq};
            wr_ptr <= wr_ptr + ptr_t'(push);
            rd_ptr <= rd_ptr + ptr_t'(pop);
            count <= count + cnt_t'(push) - cnt_t'(pop);
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            q_data[wr_ptr] <= first_data;
            q_tag[wr_ptr] <= first_meta;
        end
    end

    a_no_overflow : assert property (@(posedge clk) disable iff (reset)
        push |-> ((count < cnt_t'(DEPTH)) || pop));

endmodule

//--- reorder_top.sv
// Top level of the read-response reorder subsystem
module reorder_top
#(
    parameter int N_ENTRIES = rob_pkg::ROB_ENTRIES,
    parameter int MIN_FREE_SLOTS = rob_pkg::ROB_MIN_FREE
)
(
    input  logic                         clk,
    input  logic                         reset,

    input  logic                         req_valid,
    input  rsp_data_pkg::addr_t          req_addr,
    input  rsp_data_pkg::meta_t          req_tag,
    output logic                         req_ready,

    output logic                         mem_req_valid,
    output rsp_data_pkg::addr_t          mem_req_addr,
    output logic [$clog2(N_ENTRIES)-1:0] mem_req_idx,

    input  logic                         rsp_valid,
    input  logic [$clog2(N_ENTRIES)-1:0] rsp_idx,
    input  rsp_data_pkg::data_t          rsp_data,

    output logic                         out_valid,
    output rsp_data_pkg::data_t          out_data,
    output rsp_data_pkg::meta_t          out_tag,
    input  logic                         out_ready
);

    // ==================================================
    // Links between the three parts
    // ==================================================

    logic not_full;
    logic alloc;
    rsp_data_pkg::meta_t alloc_meta;
    logic [$clog2(N_ENTRIES)-1:0] alloc_idx;
    logic not_empty;
    logic deq;
    rsp_data_pkg::data_t first_data;
    rsp_data_pkg::meta_t first_meta;

    req_issue #(.N_ENTRIES(N_ENTRIES)) req_issue_i (.*);

    rob #(.N_ENTRIES(N_ENTRIES), .MIN_FREE_SLOTS(MIN_FREE_SLOTS)) rob_i (.*);

    ordered_out ordered_out_i (.*);

endmodule

//--- tb_reorder.sv
// Testbench for reorder_top: clock, reset, vector reading, memory responder, checker and report
module tb_reorder;

    localparam int N = rob_pkg::ROB_ENTRIES;
    localparam int IDX_W = $clog2(N);
    localparam int STALL_LIMIT = rob_pkg::ROB_ENTRIES - rob_pkg::ROB_MIN_FREE;
    localparam int MAX_VEC = 64;

    logic clk = 1'b0;
    logic reset = 1'b1;
    logic req_valid = 1'b0;
    rsp_data_pkg::addr_t req_addr = '0;
    rsp_data_pkg::meta_t req_tag = '0;
    logic req_ready;
    logic mem_req_valid;
    rsp_data_pkg::addr_t mem_req_addr;
    logic [IDX_W-1:0] mem_req_idx;
    logic rsp_valid = 1'b0;
    logic [IDX_W-1:0] rsp_idx = '0;
    rsp_data_pkg::data_t rsp_data = '0;
    logic out_valid;
    rsp_data_pkg::data_t out_data;
    rsp_data_pkg::meta_t out_tag;
    logic out_ready = 1'b1;

    reorder_top dut_i (.*);

    // ==================================================
    // Vectors and scoreboard state
    // ==================================================

    rsp_data_pkg::addr_t vec_addr [MAX_VEC];
    rsp_data_pkg::meta_t vec_tag [MAX_VEC];
    rsp_data_pkg::data_t vec_data [MAX_VEC];
    int vec_delay [MAX_VEC];
    int nvec = 0;

    // Expected words in request order, and vector numbers in issue order
    rsp_data_pkg::data_t exp_data [$];
    rsp_data_pkg::meta_t exp_tag [$];
    int issued_vec [$];

    // Responses waiting for their due cycle
    logic [IDX_W-1:0] pend_idx [$];
    int pend_due [$];
    rsp_data_pkg::data_t pend_data [$];

    int cycle = 0;
    int strobes = 0;
    int words = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    logic rsp_hold = 1'b0;
    logic bp_mode = 1'b0;
    logic sending = 1'b0;
    logic [31:0] rnd_state = 32'd64717;

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Sink readiness, random only while a back-pressure phase runs
    always @(posedge clk)
    begin
        rnd_state = xorshift(rnd_state);
        out_ready <= bp_mode ? rnd_state[7] : 1'b1;
    end

    // ==================================================
    // Memory responder
    // ==================================================

    // Strobes are recorded at the falling edge where they are stable
    always @(negedge clk)
    begin
        int v;
        if (!reset && mem_req_valid)
        begin
            if (issued_vec.size() == 0)
            begin
                $display("Memory request strobe seen with no accepted request behind it");
                errors++;
            end
            else
            begin
                v = issued_vec.pop_front();
                checks++;
                assert (mem_req_addr == vec_addr[v])
                else
                begin
                    $display("ERR t=%0t mem_req_addr expected %h got %h",
                        $time, vec_addr[v], mem_req_addr);
                    errors++;
                end
                pend_idx.push_back(mem_req_idx);
                pend_due.push_back(cycle + vec_delay[v]);
                pend_data.push_back(vec_data[v]);
            end
            strobes++;
        end
    end

    // At most one due response per cycle, the oldest due entry first
    always @(posedge clk)
    begin
        int sel;
        sel = -1;
        rsp_valid <= 1'b0;
        if (!reset && !rsp_hold)
        begin
            for (int i = 0; i < pend_due.size(); i++)
            begin
                if (sel < 0 && pend_due[i] <= cycle)
                begin
                    sel = i;
                end
            end
            if (sel >= 0)
            begin
                rsp_valid <= 1'b1;
                rsp_idx <= pend_idx[sel];
                rsp_data <= pend_data[sel];
                pend_idx.delete(sel);
                pend_due.delete(sel);
                pend_data.delete(sel);
            end
        end
    end

    // ==================================================
    // Output checker
    // ==================================================

    always @(negedge clk)
    begin
        rsp_data_pkg::data_t ed;
        rsp_data_pkg::meta_t et;
        if (!reset && out_valid && out_ready)
        begin
            if (exp_data.size() == 0)
            begin
                $display("Output word %h arrived with no request left to match it", out_data);
                errors++;
            end
            else
            begin
                ed = exp_data.pop_front();
                et = exp_tag.pop_front();
                checks += 2;
                words++;
                assert (out_data == ed)
                else
                begin
                    $display("ERR t=%0t out_data expected %h got %h", $time, ed, out_data);
                    errors++;
                end
                assert (out_tag == et)
                else
                begin
                    $display("ERR t=%0t out_tag expected %h got %h", $time, et, out_tag);
                    errors++;
                end
            end
        end
    end

    // ==================================================
    // Stimulus tasks
    // ==================================================

    // Starts just after a rising edge and returns just after the accepting edge
    task automatic send_one(input int v);
        int t;
        logic done;
        t = 0;
        done = 1'b0;
        req_valid <= 1'b1;
        req_addr <= vec_addr[v];
        req_tag <= vec_tag[v];
        while (!done && t < 1000)
        begin
            @(negedge clk);
            if (req_ready)
            begin
                exp_data.push_back(vec_data[v]);
                exp_tag.push_back(vec_tag[v]);
                issued_vec.push_back(v);
                done = 1'b1;
            end
            @(posedge clk);
            t++;
        end
        if (!done)
        begin
            $display("Request %0d was never accepted, req_ready stayed low", v);
            errors++;
        end
    endtask

    task automatic send_list(input int first, input int cnt);
        for (int i = 0; i < cnt; i++)
        begin
            send_one((first + i) % nvec);
        end
        req_valid <= 1'b0;
    endtask

    task automatic wait_drain(input int limit);
        int t;
        t = 0;
        while ((exp_data.size() != 0 || pend_due.size() != 0 || sending) && t < limit)
        begin
            @(posedge clk);
            t++;
        end
        if (exp_data.size() != 0)
        begin
            $display("Timeout with %0d expected words never delivered", exp_data.size());
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("Test %s finished with %0d errors", name, errors - err_before);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        int fd;
        int n;
        int e0;
        int s0;
        int t;
        string line;
        rsp_data_pkg::addr_t a;
        rsp_data_pkg::meta_t g;
        rsp_data_pkg::data_t d;
        int dl;

        fd = $fopen("rsp_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the vector file rsp_vectors.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && nvec < MAX_VEC)
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%h %h %h %d", a, g, d, dl);
                    if (n == 4)
                    begin
                        vec_addr[nvec] = a;
                        vec_tag[nvec] = g;
                        vec_data[nvec] = d;
                        vec_delay[nvec] = dl;
                        nvec++;
                    end
                end
            end
            $fclose(fd);
        end

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        if (nvec > 0)
        begin
            // Reset state, then one request through the whole path
            e0 = errors;
            @(negedge clk);
            assert (!out_valid)
            else
            begin
                $display("ERR t=%0t out_valid expected 0 got %b", $time, out_valid);
                errors++;
            end
            assert (!mem_req_valid)
            else
            begin
                $display("ERR t=%0t mem_req_valid expected 0 got %b", $time, mem_req_valid);
                errors++;
            end
            assert (req_ready)
            else
            begin
                $display("ERR t=%0t req_ready expected 1 got %b", $time, req_ready);
                errors++;
            end
            checks += 3;
            @(posedge clk);
            send_list(0, 1);
            wait_drain(500);
            report("reset_state", e0);

            // Scrambled delays from the file, checking data order and tags
            e0 = errors;
            send_list(0, nvec);
            wait_drain(3000);
            report("order_and_tags", e0);

            // Responses withheld until the ring fills
            e0 = errors;
            s0 = strobes;
            rsp_hold = 1'b1;
            sending = 1'b1;
            fork
                begin
                    send_list(0, STALL_LIMIT + 2);
                    sending = 1'b0;
                end
            join_none
            t = 0;
            while (strobes - s0 < STALL_LIMIT && t < 1000)
            begin
                @(posedge clk);
                t++;
            end
            repeat (20) @(posedge clk);
            @(negedge clk);
            assert (strobes - s0 == STALL_LIMIT)
            else
            begin
                $display("ERR t=%0t mem_req_valid count expected %0d got %0d",
                    $time, STALL_LIMIT, strobes - s0);
                errors++;
            end
            assert (!req_ready)
            else
            begin
                $display("ERR t=%0t req_ready expected 0 got %b", $time, req_ready);
                errors++;
            end
            checks += 2;
            rsp_hold = 1'b0;
            wait_drain(3000);
            report("full_stall", e0);

            // Random sink stalls on the ordered output
            e0 = errors;
            bp_mode = 1'b1;
            send_list(0, nvec);
            wait_drain(5000);
            bp_mode = 1'b0;
            report("back_pressure", e0);

            // Several laps of the ring so the valid tag inverts repeatedly
            e0 = errors;
            send_list(0, 4 * nvec);
            wait_drain(10000);
            report("wraparound", e0);
        end

        $display("Tests %0d, words %0d, checks %0d, errors %0d", tests, words, checks, errors);
        if (errors == 0)
        begin
            $display("Everything OK");
        end
        else
        begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- compile.f
rsp_data_pkg.sv
rob_pkg.sv
ram_simple.sv
lutram_init.sv
rob.sv
req_issue.sv
ordered_out.sv
reorder_top.sv
tb_reorder.sv

//--- run_sim.sh
#!/bin/bash
# Build the reorder subsystem testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f compile.f --top-module tb_reorder -o tb_reorder

./obj_dir/tb_reorder > sim.log 2>&1
cat sim.log

if grep -q "Something failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "Everything OK" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi

//--- rsp_vectors.txt
# Columns: address (hex), tag (hex), response data (hex), response delay in cycles (decimal)
# One line per request, in request order
0010 01 a5a50001 12
0024 02 0badf00d 3
0038 03 12345678 27
004c 04 deadbeef 1
0060 05 cafe0005 9
0074 06 00000006 33
0088 07 fedcba98 5
009c 08 13572468 18
00b0 09 ffff0009 2
00c4 0a 8000000a 40
00d8 0b 7fffffff 7
00ec 0c 0000000c 14
0100 0d 55aa55aa 1
0114 0e aa55aa55 22
0128 0f 0f0f0f0f 6
013c 10 f0f0f0f0 31
0150 11 11111111 4
0164 12 22222222 16
0178 13 33333333 2
018c 14 44444444 25
01a0 15 55555555 8
01b4 16 66666666 11
01c8 17 77777777 36
01dc 18 88888888 3
01f0 19 99999999 19
0204 1a abcdef01 10
